//--- dv/sfx_golden.txt
# name jump_at coin_at rejump_at mute exp_busy exp_high
# Offsets in cycles from the start of the test window, -1 means no pulse
idle            -1   -1   -1  0     0     0
jump             0   -1   -1  0  7936   814
coin            -1    0   -1  0   448   224
coin_over_jump   0 1000   -1  0  7936   918
coin_then_jump 100    0   -1  0  8036   866
same_cycle       0    0   -1  0  7936   802
jump_retrigger   0   -1 2000  0  9936  1423
jump_muted       0   -1   -1  1  7936     0
coin_muted      -1    0   -1  1   448     0

//--- sfx_audio.f
+incdir+design
design/sfx_pkg.sv
design/jump_sound_player.sv
design/coin_sound_player.sv
design/sfx_mixer.sv
design/sfx_top.sv
dv/sfx_checker.sv
dv/sfx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sound-effect testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f sfx_audio.f --top-module sfx_tb --Mdir obj_dir -o sfx_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sfx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

//--- dv/sfx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sfx_tb;

    localparam int max_tests = 16;

    logic        clk;
    logic        rst_n;
    logic        jump_trigger;
    logic        coin_trigger;
    logic        mute;
    wire         audio_out;
    wire         busy;

    logic         arm;
    logic [127:0] test_name;
    int           test_idx;
    int           exp_busy;
    int           exp_high;
    int           tests_done;
    int           tests_failed;
    int           chk_errors;
    int           tb_errors;
    int           num_tests;
    int           watchdog_cycles = 0;
    logic [15:0]  lfsr_state = 16'd40643;

    // Golden table, one entry per test
    logic [127:0] names [max_tests];
    int           jump_at [max_tests];
    int           coin_at [max_tests];
    int           rejump_at [max_tests];
    int           mute_tab [max_tests];
    int           exp_busy_tab [max_tests];
    int           exp_high_tab [max_tests];

    sfx_top #(
        .frame_len (256),
        .tone_unit (4)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .jump_trigger (jump_trigger),
        .coin_trigger (coin_trigger),
        .mute         (mute),
        .audio_out    (audio_out),
        .busy         (busy)
    );

    sfx_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .audio_out    (audio_out),
        .busy         (busy),
        .arm          (arm),
        .test_name    (test_name),
        .test_idx     (test_idx),
        .exp_busy     (exp_busy),
        .exp_high     (exp_high),
        .tests_done   (tests_done),
        .tests_failed (tests_failed),
        .errors       (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic take_bits(input int nbits, output int val);
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            val = (val << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic int last_offset(input int idx);
        int m;
        m = jump_at[idx];
        if (coin_at[idx] > m) begin
            m = coin_at[idx];
        end
        if (rejump_at[idx] > m) begin
            m = rejump_at[idx];
        end
        return m;
    endfunction

    task automatic load_golden();
        int              fd;
        int              rc;
        string           line;
        logic [127:0]    nm;
        int              ja, ca, ra, mu, eb, eh;
        fd = $fopen("dv/sfx_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/sfx_golden.txt, no tests were run");
            tb_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    rc = $sscanf(line, "%s %d %d %d %d %d %d", nm, ja, ca, ra, mu, eb, eh);
                    if (rc != 7 || num_tests >= max_tests) begin
                        $display("Golden line is malformed or past the table size: %s", line);
                        tb_errors++;
                    end else begin
                        names[num_tests]        = nm;
                        jump_at[num_tests]      = ja;
                        coin_at[num_tests]      = ca;
                        rejump_at[num_tests]    = ra;
                        mute_tab[num_tests]     = mu;
                        exp_busy_tab[num_tests] = eb;
                        exp_high_tab[num_tests] = eh;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int idx);
        int gap;
        int last_at;
        int waited;
        take_bits(5, gap);
        repeat (gap + 2) @(negedge clk);  // Random idle time
        last_at   = last_offset(idx);
        test_idx  = idx;
        test_name = names[idx];
        exp_busy  = exp_busy_tab[idx];
        exp_high  = exp_high_tab[idx];
        mute      = (mute_tab[idx] != 0);
        arm       = 1'b1;
        for (int c = 0; c <= last_at; c++) begin
            jump_trigger = (c == jump_at[idx]) || (c == rejump_at[idx]);
            coin_trigger = (c == coin_at[idx]);
            @(negedge clk);
        end
        jump_trigger = 1'b0;
        coin_trigger = 1'b0;
        if (exp_busy == 0) begin
            repeat (64) @(negedge clk);  // Quiet window
        end else begin
            waited = 0;
            while (!busy && waited < 8) begin
                @(negedge clk);
                waited++;
            end
            waited = 0;
            while (busy && waited < exp_busy + 64) begin
                @(negedge clk);
                waited++;
            end
            if (busy) begin
                $display("Test %0s: busy still high %0d cycles after the last trigger",
                         names[idx], waited);
                tb_errors++;
            end
        end
        arm  = 1'b0;
        mute = 1'b0;
    endtask

    function automatic int watchdog_length();
        int total;
        total = 64;
        for (int i = 0; i < num_tests; i++) begin
            total += exp_busy_tab[i] + last_offset(i) + 160;  // Gap, quiet window, tail
        end
        return 2 * total + 20;
    endfunction

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst_n        = 1'b0;
        jump_trigger = 1'b0;
        coin_trigger = 1'b0;
        mute         = 1'b0;
        arm          = 1'b0;
        test_name    = '0;
        test_idx     = 0;
        exp_busy     = 0;
        exp_high     = 0;
        tb_errors    = 0;
        num_tests    = 0;
        load_golden();
        watchdog_cycles = watchdog_length();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        repeat (4) @(negedge clk);
        $display("Tests run %0d of %0d, failed %0d, checker errors %0d, testbench errors %0d",
                 tests_done, num_tests, tests_failed, chk_errors, tb_errors);
        if (num_tests > 0 && tests_done == num_tests && tests_failed == 0 &&
            chk_errors == 0 && tb_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/sfx_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sfx_checker (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         audio_out,
    input  wire         busy,
    input  wire         arm,        // High for the length of one test window
    input  wire [127:0] test_name,
    input  wire [31:0]  test_idx,
    input  wire [31:0]  exp_busy,
    input  wire [31:0]  exp_high,
    output int          tests_done,
    output int          tests_failed,
    output int          errors
);

    int   busy_cnt = 0;
    int   high_cnt = 0;
    int   rise_cnt = 0;   // Busy pulses seen in the window
    int   done_cnt = 0;
    int   fail_cnt = 0;
    int   err_cnt = 0;
    logic arm_q = 1'b0;
    logic busy_q = 1'b0;
    logic stray_seen = 1'b0;

    assign tests_done   = done_cnt;
    assign tests_failed = fail_cnt;
    assign errors       = err_cnt;

    task automatic finish_test();
        int bad;
        int exp_rises;
        bad = 0;
        exp_rises = (exp_busy != 0) ? 1 : 0;
        if (busy_cnt != exp_busy) begin
            $display("ERROR at %t: busy length in test %0s expected %0d, actual %0d",
                     $time, test_name, exp_busy, busy_cnt);
            bad++;
        end
        if (high_cnt != exp_high) begin
            $display("ERROR at %t: audio_out high count in test %0s expected %0d, actual %0d",
                     $time, test_name, exp_high, high_cnt);
            bad++;
        end
        if (rise_cnt != exp_rises) begin
            $display("Test %0s: busy rose %0d times but should have given %0d pulse",
                     test_name, rise_cnt, exp_rises);
            bad++;
        end
        done_cnt++;
        err_cnt += bad;
        if (bad != 0) begin
            fail_cnt++;
        end
        $display("Test %0d %0s: busy %0d cycles, audio_out high %0d cycles, %0d mismatches",
                 test_idx, test_name, busy_cnt, high_cnt, bad);
    endtask

    // Samples taken at the rising edge see the values of the cycle before it
    always @(posedge clk) begin
        if (rst_n) begin
            if (arm) begin
                if (busy) begin
                    busy_cnt++;
                end
                if (audio_out) begin
                    high_cnt++;
                end
                if (busy && !busy_q) begin
                    rise_cnt++;
                end
            end else if (arm_q) begin
                finish_test();
                busy_cnt = 0;
                high_cnt = 0;
                rise_cnt = 0;
            end else if ((busy || audio_out) && !stray_seen) begin
                $display("audio_out or busy went high at %t outside any test window", $time);
                stray_seen = 1'b1;
                err_cnt++;
            end
        end
        arm_q  = arm;
        busy_q = busy;
    end

endmodule

`default_nettype wire

//--- design/sfx_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sfx_consts.svh"

module sfx_top #(
    parameter int unsigned frame_len = `SFX_FRAME_DEFAULT,
    parameter int unsigned tone_unit = `SFX_TONE_UNIT_DEFAULT
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  jump_trigger,
    input  wire  coin_trigger,
    input  wire  mute,
    output logic audio_out,
    output logic busy
);

    logic jump_wave;
    logic jump_busy;
    logic coin_wave;
    logic coin_busy;

    jump_sound_player #(
        .frame_len (frame_len)
    ) u_jump (
        .clk     (clk),
        .rst_n   (rst_n),
        .trigger (jump_trigger),
        .wave    (jump_wave),
        .busy    (jump_busy)
    );

    coin_sound_player #(
        .tone_unit (tone_unit)
    ) u_coin (
        .clk     (clk),
        .rst_n   (rst_n),
        .trigger (coin_trigger),
        .wave    (coin_wave),
        .busy    (coin_busy)
    );

    sfx_mixer u_mixer (
        .clk          (clk),
        .rst_n        (rst_n),
        .jump_trigger (jump_trigger),
        .coin_trigger (coin_trigger),
        .jump_wave    (jump_wave),
        .jump_busy    (jump_busy),
        .coin_wave    (coin_wave),
        .coin_busy    (coin_busy),
        .mute         (mute),
        .audio_out    (audio_out),
        .busy         (busy)
    );

endmodule

`default_nettype wire

//--- design/sfx_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module sfx_mixer (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  jump_trigger,
    input  wire  coin_trigger,
    input  wire  jump_wave,
    input  wire  jump_busy,
    input  wire  coin_wave,
    input  wire  coin_busy,
    input  wire  mute,
    output logic audio_out,
    output logic busy
);

    sfx_pkg::sfx_id_e owner_q;    // Last started effect
    sfx_pkg::sfx_id_e cur_owner;  // Owner after handover
    logic             sel_wave;

    // Pin passes to the other effect once the owner has finished
    always_comb begin
        cur_owner = owner_q;
        if (owner_q == sfx_pkg::sfx_coin && !coin_busy && jump_busy) begin
            cur_owner = sfx_pkg::sfx_jump;
        end else if (owner_q == sfx_pkg::sfx_jump && !jump_busy && coin_busy) begin
            cur_owner = sfx_pkg::sfx_coin;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_q <= sfx_pkg::sfx_jump;
        end else if (coin_trigger) begin
            owner_q <= sfx_pkg::sfx_coin;  // Coin wins a tie
        end else if (jump_trigger) begin
            owner_q <= sfx_pkg::sfx_jump;
        end else begin
            owner_q <= cur_owner;
        end
    end

    assign sel_wave = (cur_owner == sfx_pkg::sfx_coin) ? coin_wave : jump_wave;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            audio_out <= 1'b0;
            busy      <= 1'b0;
        end else begin
            audio_out <= sel_wave && !mute;
            busy      <= jump_busy || coin_busy;  // Mute leaves busy alone
        end
    end

endmodule

`default_nettype wire

//--- design/coin_sound_player.sv
`timescale 1ns/1ps
`default_nettype none

`include "sfx_consts.svh"

module coin_sound_player #(
    parameter int unsigned tone_unit = `SFX_TONE_UNIT_DEFAULT
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  trigger,
    output logic wave,
    output logic busy
);

    localparam int tw = `SFX_TONE_W;
    localparam logic [tw-1:0] a_half_last = tw'(`SFX_COIN_A_MULT * tone_unit - 1);
    localparam logic [tw-1:0] b_half_last = tw'(`SFX_COIN_B_MULT * tone_unit - 1);
    localparam logic [4:0]    a_period_last = 5'(`SFX_COIN_A_CYCLES - 1);
    localparam logic [4:0]    b_period_last = 5'(`SFX_COIN_B_CYCLES - 1);

    sfx_pkg::player_state_e state;
    sfx_pkg::player_state_e state_next;

    logic [tw-1:0] half_cnt;    // Cycles in current half-period
    logic [4:0]    period_cnt;  // Full periods done in this tone
    logic          tone_b;      // Second tone selected
    logic [tw-1:0] half_last;
    logic [4:0]    period_last;
    logic          half_end;
    logic          tone_end;

    assign half_last   = tone_b ? b_half_last : a_half_last;
    assign period_last = tone_b ? b_period_last : a_period_last;
    assign half_end    = (half_cnt == half_last);

    // Low half of the last period closes the tone
    assign tone_end = half_end && !wave && (period_cnt == period_last);

    always_comb begin
        state_next = state;
        case (state)
            sfx_pkg::st_idle: state_next = sfx_pkg::st_idle;
            sfx_pkg::st_play: begin
                if (tone_end && tone_b) begin
                    state_next = sfx_pkg::st_done;
                end
            end
            sfx_pkg::st_done: state_next = sfx_pkg::st_idle;
            default:          state_next = sfx_pkg::st_idle;
        endcase
        if (trigger) begin
            state_next = sfx_pkg::st_play;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= sfx_pkg::st_idle;
            half_cnt   <= '0;
            period_cnt <= '0;
            tone_b     <= 1'b0;
            wave       <= 1'b0;
        end else begin
            state <= state_next;
            if (trigger) begin
                half_cnt   <= '0;
                period_cnt <= '0;
                tone_b     <= 1'b0;
                wave       <= 1'b1;  // Tone A starts high
            end else if (state == sfx_pkg::st_play) begin
                if (half_end) begin
                    half_cnt <= '0;
                    if (wave) begin
                        wave <= 1'b0;
                    end else if (tone_end) begin
                        period_cnt <= '0;
                        tone_b     <= 1'b1;
                        wave       <= !tone_b;  // Low once tone B is over
                    end else begin
                        period_cnt <= period_cnt + 5'd1;
                        wave       <= 1'b1;
                    end
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end else begin
                wave <= 1'b0;
            end
        end
    end

    assign busy = (state == sfx_pkg::st_play);

endmodule

`default_nettype wire

//--- design/jump_sound_player.sv
`timescale 1ns/1ps
`default_nettype none

`include "sfx_consts.svh"

module jump_sound_player #(
    parameter int unsigned frame_len = `SFX_FRAME_DEFAULT
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  trigger,
    output logic wave,
    output logic busy
);

    localparam int fw = `SFX_FRAME_W;
    localparam logic [fw-1:0] frame_last = fw'(frame_len - 1);
    localparam logic [4:0]    stage_last = 5'(`SFX_JUMP_STAGES - 1);

    sfx_pkg::player_state_e state;
    sfx_pkg::player_state_e state_next;

    logic [fw-1:0] counter;    // Position inside the frame
    logic [4:0]    stage;      // Decay stage index
    logic [fw-1:0] threshold;  // High time of current stage
    logic          frame_end;

    function automatic logic [7:0] stage_frac(input logic [4:0] idx);
        logic [7:0] frac;
        case (idx)
            5'd0:    frac = `SFX_DECAY_FRAC_0;
            5'd1:    frac = `SFX_DECAY_FRAC_1;
            5'd2:    frac = `SFX_DECAY_FRAC_2;
            5'd3:    frac = `SFX_DECAY_FRAC_3;
            5'd4:    frac = `SFX_DECAY_FRAC_4;
            5'd5:    frac = `SFX_DECAY_FRAC_5;
            5'd6:    frac = `SFX_DECAY_FRAC_6;
            5'd7:    frac = `SFX_DECAY_FRAC_7;
            5'd8:    frac = `SFX_DECAY_FRAC_8;
            5'd9:    frac = `SFX_DECAY_FRAC_9;
            5'd10:   frac = `SFX_DECAY_FRAC_10;
            5'd11:   frac = `SFX_DECAY_FRAC_11;
            5'd12:   frac = `SFX_DECAY_FRAC_12;
            5'd13:   frac = `SFX_DECAY_FRAC_13;
            5'd14:   frac = `SFX_DECAY_FRAC_14;
            5'd15:   frac = `SFX_DECAY_FRAC_15;
            5'd16:   frac = `SFX_DECAY_FRAC_16;
            5'd17:   frac = `SFX_DECAY_FRAC_17;
            5'd18:   frac = `SFX_DECAY_FRAC_18;
            5'd19:   frac = `SFX_DECAY_FRAC_19;
            5'd20:   frac = `SFX_DECAY_FRAC_20;
            5'd21:   frac = `SFX_DECAY_FRAC_21;
            5'd22:   frac = `SFX_DECAY_FRAC_22;
            5'd23:   frac = `SFX_DECAY_FRAC_23;
            5'd24:   frac = `SFX_DECAY_FRAC_24;
            5'd25:   frac = `SFX_DECAY_FRAC_25;
            5'd26:   frac = `SFX_DECAY_FRAC_26;
            5'd27:   frac = `SFX_DECAY_FRAC_27;
            5'd28:   frac = `SFX_DECAY_FRAC_28;
            5'd29:   frac = `SFX_DECAY_FRAC_29;
            5'd30:   frac = `SFX_DECAY_FRAC_30;
            default: frac = 8'd0;
        endcase
        return frac;
    endfunction

    // frame_len * frac / 256, rounded down
    function automatic logic [fw-1:0] stage_thr(input logic [4:0] idx);
        logic [fw+7:0] prod;
        prod = (fw+8)'(frame_len) * stage_frac(idx);
        return prod[fw+7:8];
    endfunction

    assign frame_end = (counter == frame_last);

    always_comb begin
        state_next = state;
        case (state)
            sfx_pkg::st_idle: state_next = sfx_pkg::st_idle;
            sfx_pkg::st_play: begin
                if (frame_end && stage == stage_last) begin
                    state_next = sfx_pkg::st_done;
                end
            end
            sfx_pkg::st_done: state_next = sfx_pkg::st_idle;
            default:          state_next = sfx_pkg::st_idle;
        endcase
        if (trigger) begin
            state_next = sfx_pkg::st_play;  // Retrigger wins
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= sfx_pkg::st_idle;
            counter <= '0;
            stage   <= '0;
        end else begin
            state <= state_next;
            if (trigger) begin
                counter   <= '0;
                stage     <= '0;
                threshold <= stage_thr(5'd0);
            end else if (state == sfx_pkg::st_play) begin
                if (frame_end) begin
                    counter <= '0;
                    if (stage != stage_last) begin
                        stage     <= stage + 5'd1;
                        threshold <= stage_thr(stage + 5'd1);
                    end
                end else begin
                    counter <= counter + 1'b1;
                end
            end
        end
    end

    assign busy = (state == sfx_pkg::st_play);
    assign wave = busy && (counter < threshold);

endmodule

`default_nettype wire

//--- design/sfx_pkg.sv
`default_nettype none

package sfx_pkg;

    // Common FSM for both one-shot players
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_play = 2'd1,
        st_done = 2'd2
    } player_state_e;

    // Effect that currently drives the pin
    typedef enum logic {
        sfx_jump = 1'b0,
        sfx_coin = 1'b1
    } sfx_id_e;

endpackage

`default_nettype wire

//--- design/sfx_consts.svh
`ifndef SFX_CONSTS_SVH
`define SFX_CONSTS_SVH

// Jump effect
`define SFX_JUMP_STAGES       31
`define SFX_FRAME_DEFAULT     333333  // 150 Hz frame at 50 MHz
`define SFX_FRAME_W           19

// Duty per stage in 256ths of the frame
`define SFX_DECAY_FRAC_0      8'd128
`define SFX_DECAY_FRAC_1      8'd108
`define SFX_DECAY_FRAC_2      8'd91
`define SFX_DECAY_FRAC_3      8'd77
`define SFX_DECAY_FRAC_4      8'd65
`define SFX_DECAY_FRAC_5      8'd55
`define SFX_DECAY_FRAC_6      8'd46
`define SFX_DECAY_FRAC_7      8'd39
`define SFX_DECAY_FRAC_8      8'd33
`define SFX_DECAY_FRAC_9      8'd28
`define SFX_DECAY_FRAC_10     8'd23
`define SFX_DECAY_FRAC_11     8'd20
`define SFX_DECAY_FRAC_12     8'd17
`define SFX_DECAY_FRAC_13     8'd14
`define SFX_DECAY_FRAC_14     8'd12
`define SFX_DECAY_FRAC_15     8'd10
`define SFX_DECAY_FRAC_16     8'd8
`define SFX_DECAY_FRAC_17     8'd7
`define SFX_DECAY_FRAC_18     8'd6
`define SFX_DECAY_FRAC_19     8'd5
`define SFX_DECAY_FRAC_20     8'd4
`define SFX_DECAY_FRAC_21     8'd4
`define SFX_DECAY_FRAC_22     8'd3
`define SFX_DECAY_FRAC_23     8'd3
`define SFX_DECAY_FRAC_24     8'd2
`define SFX_DECAY_FRAC_25     8'd2
`define SFX_DECAY_FRAC_26     8'd2
`define SFX_DECAY_FRAC_27     8'd1
`define SFX_DECAY_FRAC_28     8'd1
`define SFX_DECAY_FRAC_29     8'd0
`define SFX_DECAY_FRAC_30     8'd0

// Coin effect
`define SFX_TONE_UNIT_DEFAULT 8446  // About 986 Hz for tone A
`define SFX_TONE_W            18
`define SFX_COIN_A_MULT       3
`define SFX_COIN_B_MULT       2
`define SFX_COIN_A_CYCLES     8
`define SFX_COIN_B_CYCLES     16

`endif
